/* run.sh */
#!/usr/bin/env bash
# Build and run the video testbench with Verilator

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --timescale 1ns/1ps -f tb.f \
    --top-module tbVideo -Mdir "$buildDir" -o tbVideo
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$buildDir/tbVideo" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "Simulator exited with status $simStatus"
fi

# Pass only if the testbench printed its pass line
if grep -qx "TEST OK" "$logFile"; then
    exit 0
fi
echo "Simulation did not pass, see $logFile"
exit 1

/* src/patternStage.sv */
`timescale 1ns/1ps

module patternStage
(
    input  logic                            Reset,
    input  logic                            Clk,

    // Raster state, current cycle
    input  logic [videoPkg::CoordWidth-1:0] hCount,
    input  logic [videoPkg::CoordWidth-1:0] vCount,
    input  logic                            hSyncRaw,
    input  logic                            vSyncRaw,
    input  logic                            displayRaw,

    // Register settings
    input  logic                            enable,
    input  videoPkg::PatternWord            pattern,

    // Video out, one cycle behind the counters
    output logic [videoPkg::CoordWidth-1:0] drawX,
    output logic [videoPkg::CoordWidth-1:0] drawY,
    output logic                            hSync,
    output logic                            vSync,
    output logic                            blank,
    output logic [3:0]                      red,
    output logic [3:0]                      green,
    output logic [3:0]                      blue
);

    // Column and row bit picked by the width shift
    logic                            hBit;
    logic                            vBit;
    // High selects colourB
    logic                            pickB;
    logic [videoPkg::ColorWidth-1:0] colorNext;
    logic [videoPkg::ColorWidth-1:0] colorReg;

    // ----------------------------------------------------------------------
    // Colour decode
    // ----------------------------------------------------------------------

    // Stripe width is 2**widthShift pixels
    assign hBit = hCount[pattern.bars.widthShift];
    assign vBit = vCount[pattern.bars.widthShift];

    always_comb
    begin
        pickB     = 1'b0;
        colorNext = pattern.solid.color;
        case (pattern.bars.mode)
            videoPkg::PatBars:
            begin
                pickB     = hBit;
                colorNext = pickB ? pattern.bars.colorB : pattern.bars.colorA;
            end
            videoPkg::PatChecker:
            begin
                pickB     = hBit ^ vBit;
                colorNext = pickB ? pattern.bars.colorB : pattern.bars.colorA;
            end
            // Solid and the spare code
            default:
                colorNext = pattern.solid.color;
        endcase

        // Black when off or outside the drawing area
        if (!enable || !displayRaw)
            colorNext = '0;
    end

    // ----------------------------------------------------------------------
    // Output stage
    // ----------------------------------------------------------------------

    // Colour, syncs and coordinates move together so they always agree
    always_ff @(posedge Reset or posedge Clk)
    begin
        if (Clk)
        begin
            drawX    <= '0;
            drawY    <= '0;
            hSync    <= 1'b0;
            vSync    <= 1'b0;
            blank    <= 1'b0;
            colorReg <= '0;
        end
        else
        begin
            drawX    <= hCount;
            drawY    <= vCount;
            hSync    <= hSyncRaw;
            vSync    <= vSyncRaw;
            blank    <= displayRaw;
            colorReg <= colorNext;
        end
    end

    // 4:4:4 split
    assign red   = colorReg[11:8];
    assign green = colorReg[7:4];
    assign blue  = colorReg[3:0];

endmodule

/* src/videoCtrl.sv */
`timescale 1ns/1ps

module videoCtrl
(
    input  logic                Reset,
    input  logic                Clk,

    // APB slave
    input  logic                pSel,
    input  logic                pEnable,
    input  logic                pWrite,
    input  logic [3:0]          pAddr,
    input  logic [31:0]         pWData,
    output logic [31:0]         pRData,
    output logic                pReady,
    output logic                pSlvErr,

    // From the raster counters
    input  logic                frameStart,

    // To the pattern stage
    output logic                enable,
    output videoPkg::PatternWord pattern
);

    // Access phase of a transfer
    logic        access;
    // Offset hits one of the three registers
    logic        addrValid;
    // Write that actually updates a register
    logic        writeOk;
    // Frames seen since reset, wraps
    logic [15:0] frameCount;
    // Read mux before the pSel gate
    logic [31:0] readData;

    // ----------------------------------------------------------------------
    // Phase and address decode
    // ----------------------------------------------------------------------

    assign access = pSel && pEnable;

    always_comb
    begin
        case (pAddr)
            videoPkg::AddrCtrl,
            videoPkg::AddrPattern,
            videoPkg::AddrStatus:
                addrValid = 1'b1;
            default:
                addrValid = 1'b0;
        endcase
    end

    // Never stalls
    assign pReady = 1'b1;

    // Unknown offset, or an attempt to write read-only STATUS
    assign pSlvErr = access &&
                     (!addrValid || (pWrite && (pAddr == videoPkg::AddrStatus)));

    assign writeOk = access && pWrite && !pSlvErr;

    // ----------------------------------------------------------------------
    // Registers
    // ----------------------------------------------------------------------

    always_ff @(posedge Reset or posedge Clk)
    begin
        if (Clk)
        begin
            enable     <= 1'b0;
            pattern    <= '0;
            frameCount <= '0;
        end
        else
        begin
            // Count every frame start, enabled or not
            if (frameStart)
                frameCount <= frameCount + 1'b1;

            // Write lands at the end of the access cycle
            if (writeOk)
            begin
                case (pAddr)
                    videoPkg::AddrCtrl:
                        enable <= pWData[0];
                    videoPkg::AddrPattern:
                        pattern <= pWData;
                    default:
                        ;
                endcase
            end
        end
    end

    // ----------------------------------------------------------------------
    // Read data
    // ----------------------------------------------------------------------

    always_comb
    begin
        case (pAddr)
            videoPkg::AddrCtrl:
                readData = {31'b0, enable};
            videoPkg::AddrPattern:
                readData = pattern;
            // Bit 16 mirrors enable, low half is the frame count
            videoPkg::AddrStatus:
                readData = {15'b0, enable, frameCount};
            default:
                readData = '0;
        endcase
    end

    // Zero outside reads
    assign pRData = (pSel && !pWrite) ? readData : '0;

endmodule

/* src/videoPkg.sv */
package videoPkg;

    // ----------------------------------------------------------------------
    // Widths
    // ----------------------------------------------------------------------

    // Raster counters and drawing coordinates
    localparam int CoordWidth = 11;

    // One packed 4:4:4 RGB value, red in the top nibble
    localparam int ColorWidth = 12;

    // ----------------------------------------------------------------------
    // APB register map, byte offsets
    // ----------------------------------------------------------------------

    localparam logic [3:0] AddrCtrl    = 4'd0;
    localparam logic [3:0] AddrPattern = 4'd4;
    localparam logic [3:0] AddrStatus  = 4'd8;

    // ----------------------------------------------------------------------
    // Pattern modes
    // ----------------------------------------------------------------------

    // Code 3 is not defined and falls back to solid
    localparam logic [1:0] PatSolid   = 2'd0;
    localparam logic [1:0] PatBars    = 2'd1;
    localparam logic [1:0] PatChecker = 2'd2;

    // Pattern register word
    // Mode sits in bits 1:0 in both views and picks the decode
    typedef union packed {
        // Single flat colour
        struct packed {
            logic [ColorWidth-1:0] color;
            logic [17:0]           pad;
            logic [1:0]            mode;
        } solid;
        // Two colours, used by both bars and checker
        struct packed {
            logic [2:0]            spare;
            logic [ColorWidth-1:0] colorB;
            logic [ColorWidth-1:0] colorA;
            logic [2:0]            widthShift;
            logic [1:0]            mode;
        } bars;
    } PatternWord;

endpackage

/* src/videoTiming.sv */
`timescale 1ns/1ps

module videoTiming
#(
    parameter logic [videoPkg::CoordWidth-1:0] HActive    = 11'd1280,
    parameter logic [videoPkg::CoordWidth-1:0] HSyncStart = 11'd1328,
    parameter logic [videoPkg::CoordWidth-1:0] HSyncEnd   = 11'd1440,
    parameter logic [videoPkg::CoordWidth-1:0] HTotal     = 11'd1687,
    parameter logic [videoPkg::CoordWidth-1:0] VActive    = 11'd1024,
    parameter logic [videoPkg::CoordWidth-1:0] VSyncStart = 11'd1025,
    parameter logic [videoPkg::CoordWidth-1:0] VSyncEnd   = 11'd1028,
    parameter logic [videoPkg::CoordWidth-1:0] VTotal     = 11'd1065
)
(
    input  logic                            Reset,
    input  logic                            Clk,
    output logic [videoPkg::CoordWidth-1:0] hCount,
    output logic [videoPkg::CoordWidth-1:0] vCount,
    output logic                            hSyncRaw,
    output logic                            vSyncRaw,
    output logic                            displayRaw,
    output logic                            frameStart
);

    // Counter values after the coming edge
    logic [videoPkg::CoordWidth-1:0] hNext;
    logic [videoPkg::CoordWidth-1:0] vNext;
    logic                            lineEnd;

    // ----------------------------------------------------------------------
    // Next count
    // ----------------------------------------------------------------------

    assign lineEnd = (hCount == HTotal);

    always_comb
    begin
        // Pixel counter wraps after the last count
        if (lineEnd)
            hNext = '0;
        else
            hNext = hCount + 1'b1;

        // Line counter only moves on a pixel wrap
        if (!lineEnd)
            vNext = vCount;
        else if (vCount == VTotal)
            vNext = '0;
        else
            vNext = vCount + 1'b1;
    end

    // ----------------------------------------------------------------------
    // Counters and syncs
    // ----------------------------------------------------------------------

    always_ff @(posedge Reset or posedge Clk)
    begin
        if (Clk)
        begin
            hCount   <= '0;
            vCount   <= '0;
            // Syncs come out of reset low
            hSyncRaw <= 1'b0;
            vSyncRaw <= 1'b0;
        end
        else
        begin
            hCount   <= hNext;
            vCount   <= vNext;
            // Decoded from the next count so they line up with the counters
            hSyncRaw <= !((hNext >= HSyncStart) && (hNext < HSyncEnd));
            vSyncRaw <= !((vNext >= VSyncStart) && (vNext < VSyncEnd));
        end
    end

    // High inside the drawing area of the current counts
    assign displayRaw = (hCount < HActive) && (vCount < VActive);

    // First pixel of a frame
    assign frameStart = (hCount == '0) && (vCount == '0);

endmodule

/* src/videoTop.sv */
`timescale 1ns/1ps

module videoTop
#(
    // Default raster is 1280x1024
    parameter logic [videoPkg::CoordWidth-1:0] HActive    = 11'd1280,
    parameter logic [videoPkg::CoordWidth-1:0] HSyncStart = 11'd1328,
    parameter logic [videoPkg::CoordWidth-1:0] HSyncEnd   = 11'd1440,
    parameter logic [videoPkg::CoordWidth-1:0] HTotal     = 11'd1687,
    parameter logic [videoPkg::CoordWidth-1:0] VActive    = 11'd1024,
    parameter logic [videoPkg::CoordWidth-1:0] VSyncStart = 11'd1025,
    parameter logic [videoPkg::CoordWidth-1:0] VSyncEnd   = 11'd1028,
    parameter logic [videoPkg::CoordWidth-1:0] VTotal     = 11'd1065
)
(
    input  logic                            Reset,
    input  logic                            Clk,

    // APB slave
    input  logic                            pSel,
    input  logic                            pEnable,
    input  logic                            pWrite,
    input  logic [3:0]                      pAddr,
    input  logic [31:0]                     pWData,
    output logic [31:0]                     pRData,
    output logic                            pReady,
    output logic                            pSlvErr,

    // Video
    output logic                            hSync,
    output logic                            vSync,
    output logic                            blank,
    output logic [3:0]                      red,
    output logic [3:0]                      green,
    output logic [3:0]                      blue,
    output logic [videoPkg::CoordWidth-1:0] drawX,
    output logic [videoPkg::CoordWidth-1:0] drawY
);

    // ----------------------------------------------------------------------
    // Internal wiring
    // ----------------------------------------------------------------------

    logic [videoPkg::CoordWidth-1:0] hCount;
    logic [videoPkg::CoordWidth-1:0] vCount;
    logic                            hSyncRaw;
    logic                            vSyncRaw;
    logic                            displayRaw;
    logic                            frameStart;
    logic                            enable;
    videoPkg::PatternWord            pattern;

    // Raster counters and syncs
    videoTiming #(
        .HActive    (HActive),
        .HSyncStart (HSyncStart),
        .HSyncEnd   (HSyncEnd),
        .HTotal     (HTotal),
        .VActive    (VActive),
        .VSyncStart (VSyncStart),
        .VSyncEnd   (VSyncEnd),
        .VTotal     (VTotal)
    ) timing (
        .Reset      (Reset),
        .Clk        (Clk),
        .hCount     (hCount),
        .vCount     (vCount),
        .hSyncRaw   (hSyncRaw),
        .vSyncRaw   (vSyncRaw),
        .displayRaw (displayRaw),
        .frameStart (frameStart)
    );

    // Register block
    videoCtrl ctrl (
        .Reset      (Reset),
        .Clk        (Clk),
        .pSel       (pSel),
        .pEnable    (pEnable),
        .pWrite     (pWrite),
        .pAddr      (pAddr),
        .pWData     (pWData),
        .pRData     (pRData),
        .pReady     (pReady),
        .pSlvErr    (pSlvErr),
        .frameStart (frameStart),
        .enable     (enable),
        .pattern    (pattern)
    );

    // Colour and output register
    patternStage pixel (
        .Reset      (Reset),
        .Clk        (Clk),
        .hCount     (hCount),
        .vCount     (vCount),
        .hSyncRaw   (hSyncRaw),
        .vSyncRaw   (vSyncRaw),
        .displayRaw (displayRaw),
        .enable     (enable),
        .pattern    (pattern),
        .drawX      (drawX),
        .drawY      (drawY),
        .hSync      (hSync),
        .vSync      (vSync),
        .blank      (blank),
        .red        (red),
        .green      (green),
        .blue       (blue)
    );

endmodule

/* tb.f */
+incdir+testbench
src/videoPkg.sv
src/videoTiming.sv
src/videoCtrl.sv
src/patternStage.sv
src/videoTop.sv
testbench/tbVideo.sv

/* testbench/tbModel.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// ----------------------------------------------------------------------
// Reference model of the raster outputs
// ----------------------------------------------------------------------

// Active-low syncs, horizontal in bit 1 and vertical in bit 0
function automatic logic [1:0] expectSync(input logic [10:0] x, input logic [10:0] y);
    return {!((x >= HSyncStart) && (x < HSyncEnd)), !((y >= VSyncStart) && (y < VSyncEnd))};
endfunction

// High inside the drawing area
function automatic logic expectBlank(input logic [10:0] x, input logic [10:0] y);
    return (x < HActive) && (y < VActive);
endfunction

// Colour decoded straight from the bit layout of the pattern word
function automatic logic [11:0] expectColor(input logic [10:0] x, input logic [10:0] y,
                                            input logic [31:0] pat, input logic en);
    int         shift;
    logic [11:0] colA;
    logic [11:0] colB;
    logic       useB;
    shift = int'(pat[4:2]);
    colA  = pat[16:5];
    colB  = pat[28:17];
    // Black when off or outside the drawing area
    if (!en || !expectBlank(x, y))
        return 12'h000;
    case (pat[1:0])
        videoPkg::PatBars:
            useB = x[shift];
        videoPkg::PatChecker:
            useB = x[shift] ^ y[shift];
        // Solid and the undefined code
        default:
            return pat[31:20];
    endcase
    return useB ? colB : colA;
endfunction

// ----------------------------------------------------------------------
// Random numbers and checking
// ----------------------------------------------------------------------

logic [31:0] lcgState = 32'hf461_9fcd;

function automatic logic [31:0] nextRandom();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
endfunction

task automatic abortSim();
    $display("TEST FAILED");
    $fatal(1);
endtask

task automatic check(input string name, input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual)
    begin
        $display("Error: %s (%s) expected %h actual %h", name, phase, expected, actual);
        abortSim();
    end
endtask

`endif

/* testbench/tbVideo.sv */
`timescale 1ns/1ps

module tbVideo;

    // Tiny raster, 32 x 14 counts per frame
    localparam logic [10:0] HActive    = 11'd16;
    localparam logic [10:0] HSyncStart = 11'd20;
    localparam logic [10:0] HSyncEnd   = 11'd24;
    localparam logic [10:0] HTotal     = 11'd31;
    localparam logic [10:0] VActive    = 11'd8;
    localparam logic [10:0] VSyncStart = 11'd9;
    localparam logic [10:0] VSyncEnd   = 11'd11;
    localparam logic [10:0] VTotal     = 11'd13;
    localparam int          FrameCycles = 32 * 14;
    localparam int          ApbTimeout  = 8;

    // Clock is Reset and reset is Clk, as on the DUT
    logic        Reset;
    logic        Clk;
    logic        pSel;
    logic        pEnable;
    logic        pWrite;
    logic [3:0]  pAddr;
    logic [31:0] pWData;
    logic [31:0] pRData;
    logic        pReady;
    logic        pSlvErr;
    logic        hSync;
    logic        vSync;
    logic        blank;
    logic [3:0]  red;
    logic [3:0]  green;
    logic [3:0]  blue;
    logic [videoPkg::CoordWidth-1:0] drawX;
    logic [videoPkg::CoordWidth-1:0] drawY;

    // Register state as the testbench wrote it, and a copy one cycle behind
    logic        modelEnable;
    logic [31:0] modelPattern;
    logic        lagEnable;
    logic [31:0] lagPattern;
    // Frame wraps seen on drawX and drawY
    int          wrapCount;
    string       phase;

    `include "tbModel.svh"

    videoTop #(
        .HActive (HActive), .HSyncStart (HSyncStart), .HSyncEnd (HSyncEnd), .HTotal (HTotal),
        .VActive (VActive), .VSyncStart (VSyncStart), .VSyncEnd (VSyncEnd), .VTotal (VTotal)
    ) dut (
        .Reset (Reset), .Clk (Clk),
        .pSel (pSel), .pEnable (pEnable), .pWrite (pWrite), .pAddr (pAddr), .pWData (pWData),
        .pRData (pRData), .pReady (pReady), .pSlvErr (pSlvErr),
        .hSync (hSync), .vSync (vSync), .blank (blank),
        .red (red), .green (green), .blue (blue), .drawX (drawX), .drawY (drawY)
    );

    // 40 ns clock
    initial
    begin
        Reset = 1'b0;
        forever
            #20 Reset = ~Reset;
    end

    // ----------------------------------------------------------------------
    // APB master
    // ----------------------------------------------------------------------

    task automatic apbWrite(input logic [3:0] addr, input logic [31:0] data, input logic expectErr);
        int   waitCycles;
        logic gotErr;
        @(posedge Reset);
        pSel    <= 1'b1;
        pEnable <= 1'b0;
        pWrite  <= 1'b1;
        pAddr   <= addr;
        pWData  <= data;
        @(posedge Reset);
        pEnable <= 1'b1;
        waitCycles = 0;
        @(negedge Reset);
        while (!pReady)
        begin
            waitCycles++;
            if (waitCycles > ApbTimeout)
            begin
                $display("Timeout: APB write got no pReady");
                abortSim();
            end
            @(negedge Reset);
        end
        gotErr = pSlvErr;
        // Write lands on this edge
        @(posedge Reset);
        pSel    <= 1'b0;
        pEnable <= 1'b0;
        pWrite  <= 1'b0;
        check("write error flag", 32'(expectErr), 32'(gotErr));
        if (!expectErr && addr == videoPkg::AddrCtrl)
            modelEnable = data[0];
        else if (!expectErr && addr == videoPkg::AddrPattern)
            modelPattern = data;
    endtask

    task automatic apbRead(input logic [3:0] addr, input logic expectErr,
                           output logic [31:0] data, output int frames);
        int   waitCycles;
        logic gotErr;
        @(posedge Reset);
        pSel    <= 1'b1;
        pEnable <= 1'b0;
        pWrite  <= 1'b0;
        pAddr   <= addr;
        @(posedge Reset);
        pEnable <= 1'b1;
        waitCycles = 0;
        @(negedge Reset);
        while (!pReady)
        begin
            waitCycles++;
            if (waitCycles > ApbTimeout)
            begin
                $display("Timeout: APB read got no pReady");
                abortSim();
            end
            @(negedge Reset);
        end
        data   = pRData;
        gotErr = pSlvErr;
        @(posedge Reset);
        // Wraps counted up to the sample above
        frames  = wrapCount;
        pSel    <= 1'b0;
        pEnable <= 1'b0;
        check("read error flag", 32'(expectErr), 32'(gotErr));
    endtask

    // Wait for a number of frame wraps on the outputs
    task automatic waitFrames(input int count);
        int startWraps;
        int cycles;
        startWraps = wrapCount;
        cycles     = 0;
        while (wrapCount - startWraps < count)
        begin
            @(posedge Reset);
            cycles++;
            if (cycles > (count + 1) * FrameCycles)
            begin
                $display("Timeout: the raster did not wrap in time");
                abortSim();
            end
        end
    endtask

    // ----------------------------------------------------------------------
    // Compare process
    // ----------------------------------------------------------------------

    // Samples at the falling edge, away from the DUT's update edge
    initial
    begin : compare
        int          samples;
        logic [10:0] prevX;
        logic [10:0] prevY;
        logic [10:0] stepX;
        logic [10:0] stepY;
        samples = 0;
        prevX   = '0;
        prevY   = '0;
        forever
        begin
            @(negedge Reset);
            if (Clk)
                samples = 0;
            else
            begin
                samples++;
                // First two samples still carry the reset values of the syncs
                if (samples >= 3)
                begin
                    stepX = (prevX == HTotal) ? 11'd0 : prevX + 11'd1;
                    if (prevX != HTotal)
                        stepY = prevY;
                    else if (prevY == VTotal)
                        stepY = 11'd0;
                    else
                        stepY = prevY + 11'd1;
                    check("raster x", 32'(stepX), 32'(drawX));
                    check("raster y", 32'(stepY), 32'(drawY));
                    check("sync", 32'(expectSync(drawX, drawY)), 32'({hSync, vSync}));
                    check("blank", 32'(expectBlank(drawX, drawY)), 32'(blank));
                    check("colour", 32'(expectColor(drawX, drawY, lagPattern, lagEnable)),
                          32'({red, green, blue}));
                    if (drawX == 11'd0 && drawY == 11'd0)
                        wrapCount++;
                end
                prevX      = drawX;
                prevY      = drawY;
                lagEnable  = modelEnable;
                lagPattern = modelPattern;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------------------

    initial
    begin : testSeq
        logic [31:0] rnd;
        logic [31:0] word;
        logic [31:0] data;
        logic [31:0] statusA;
        logic [31:0] statusB;
        logic [11:0] colA;
        logic [11:0] colB;
        int          framesA;
        int          framesB;
        Clk          = 1'b1;
        pSel         = 1'b0;
        pEnable      = 1'b0;
        pWrite       = 1'b0;
        pAddr        = 4'd0;
        pWData       = 32'h0;
        modelEnable  = 1'b0;
        modelPattern = 32'h0;
        lagEnable    = 1'b0;
        lagPattern   = 32'h0;
        wrapCount    = 0;
        phase        = "reset";
        repeat (5) @(posedge Reset);
        Clk <= 1'b0;

        // Registers clear, output black while disabled
        apbRead(videoPkg::AddrCtrl, 1'b0, data, framesA);
        check("ctrl after reset", 32'h0, data);
        apbRead(videoPkg::AddrPattern, 1'b0, data, framesA);
        check("pattern after reset", 32'h0, data);
        apbRead(videoPkg::AddrStatus, 1'b0, data, framesA);
        check("status enable after reset", 32'h0, data & 32'hffff_0000);
        waitFrames(1);

        // Solid colour, random padding bits too
        phase = "solid";
        rnd   = nextRandom();
        word  = {rnd[31:20], rnd[19:2], videoPkg::PatSolid};
        apbWrite(videoPkg::AddrPattern, word, 1'b0);
        apbWrite(videoPkg::AddrCtrl, 32'h1, 1'b0);
        apbRead(videoPkg::AddrPattern, 1'b0, data, framesA);
        check("pattern readback", word, data);
        apbRead(videoPkg::AddrCtrl, 1'b0, data, framesA);
        check("ctrl readback", 32'h1, data);
        waitFrames(2);

        // Bars then checker, every width shift from 0 to 3
        for (int m = 0; m < 2; m++)
        begin
            phase = (m == 0) ? "bars" : "checker";
            for (int s = 0; s < 4; s++)
            begin
                rnd  = nextRandom();
                colA = rnd[27:16];
                rnd  = nextRandom();
                colB = rnd[27:16];
                word = {3'b000, colB, colA, 3'(s),
                        (m == 0) ? videoPkg::PatBars : videoPkg::PatChecker};
                apbWrite(videoPkg::AddrPattern, word, 1'b0);
                apbRead(videoPkg::AddrPattern, 1'b0, data, framesA);
                check("pattern readback", word, data);
                waitFrames(1);
            end
        end

        // Error responses, bad writes leave the registers alone
        phase = "apb";
        apbRead(4'd12, 1'b1, data, framesA);
        check("bad offset read data", 32'h0, data);
        apbWrite(4'd12, 32'hffff_ffff, 1'b1);
        apbWrite(videoPkg::AddrStatus, 32'h0, 1'b1);
        apbRead(videoPkg::AddrPattern, 1'b0, data, framesA);
        check("pattern after bad writes", word, data);

        // Frame counter against wraps seen on the outputs
        apbRead(videoPkg::AddrStatus, 1'b0, statusA, framesA);
        check("status enable bit", 32'h1, 32'(statusA[16]));
        waitFrames(3);
        apbRead(videoPkg::AddrStatus, 1'b0, statusB, framesB);
        check("status frame delta", 32'(framesB - framesA),
              {16'h0, statusB[15:0] - statusA[15:0]});

        // Back to black
        phase = "disable";
        apbWrite(videoPkg::AddrCtrl, 32'h0, 1'b0);
        waitFrames(1);

        $display("TEST OK");
        $finish;
    end

endmodule
